// ==== hw/nes_cpu_pkg.sv ====
package nes_cpu_pkg;

    // Command opcodes
    localparam logic [2:0] CMD_LOAD_A  = 3'd0;
    localparam logic [2:0] CMD_LOAD_X  = 3'd1;
    localparam logic [2:0] CMD_STORE_A = 3'd2;
    localparam logic [2:0] CMD_STORE_X = 3'd3;
    localparam logic [2:0] CMD_PUSH_A  = 3'd4;
    localparam logic [2:0] CMD_PULL_A  = 3'd5;
    localparam logic [2:0] CMD_BRK     = 3'd6;

    // Address low byte sources
    localparam logic [2:0] ADDRLO_HOLD = 3'd0;
    localparam logic [2:0] ADDRLO_CMD  = 3'd1;
    localparam logic [2:0] ADDRLO_SP   = 3'd2;
    localparam logic [2:0] ADDRLO_FE   = 3'd3;
    localparam logic [2:0] ADDRLO_FF   = 3'd4;

    // Address high byte sources
    localparam logic [1:0] ADDRHI_HOLD  = 2'd0;
    localparam logic [1:0] ADDRHI_CMD   = 2'd1;
    localparam logic [1:0] ADDRHI_STACK = 2'd2;
    localparam logic [1:0] ADDRHI_FF    = 2'd3;
    localparam logic [7:0] STACK_PAGE   = 8'h01;

    localparam logic [2:0] WMEMSRC_A         = 3'd0;
    localparam logic [2:0] WMEMSRC_X         = 3'd1;
    localparam logic [2:0] WMEMSRC_PCHI      = 3'd2;
    localparam logic [2:0] WMEMSRC_PCLO      = 3'd3;
    localparam logic [2:0] WMEMSRC_STATUS_BS = 3'd4;

    localparam logic [2:0] REGDST_NONE = 3'd0;
    localparam logic [2:0] REGDST_A    = 3'd1;
    localparam logic [2:0] REGDST_X    = 3'd2;
    localparam logic [2:0] REGDST_PCLO = 3'd3;
    localparam logic [2:0] REGDST_PCHI = 3'd4;

    localparam logic [1:0] SPSTEP_NONE = 2'd0;
    localparam logic [1:0] SPSTEP_INC  = 2'd1;
    localparam logic [1:0] SPSTEP_DEC  = 2'd2;

    // Sequencer states
    localparam logic [1:0] SEQ_IDLE = 2'd0;
    localparam logic [1:0] SEQ_STEP = 2'd1;
    localparam logic [1:0] SEQ_RESP = 2'd2;

    localparam logic [7:0]  SP_RESET     = 8'hFD;
    localparam logic [15:0] PC_RESET     = 16'hC000;
    localparam logic [7:0]  STATUS_RESET = 8'h24;

    // NES memory map bounds one past each region end
    localparam logic [15:0] RAM_END = 16'h2000;
    localparam logic [15:0] PPU_END = 16'h4000;
    localparam logic [15:0] IO_END  = 16'h4020;

    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic n;
            logic v;
            logic unused;
            logic b;
            logic d;
            logic i;
            logic z;
            logic c;
        } flags;
    } status_t;

endpackage : nes_cpu_pkg

// ==== hw/cpu_interfaces.sv ====
`timescale 1ns/1ps

interface cpu_bus_if;
    logic [15:0] addr;
    logic        r_en;
    logic [7:0]  w_data;
    logic [7:0]  r_data;

    modport source  (output addr, output r_en, output w_data, input r_data);
    modport target  (input addr, input r_en, input w_data, output r_data);
    modport monitor (input r_data);
endinterface : cpu_bus_if

interface ucode_if;
    logic [2:0] addr_lo_src;
    logic [1:0] addr_hi_src;
    logic       mem_r_en;
    logic [2:0] wmem_src;
    logic [2:0] reg_dst;
    logic [1:0] sp_step;
    logic       set_i;
    logic       set_nz;

    modport controller (
        output addr_lo_src, output addr_hi_src, output mem_r_en, output wmem_src,
        output reg_dst, output sp_step, output set_i, output set_nz
    );
    modport datapath (input addr_lo_src, input addr_hi_src, input mem_r_en, input wmem_src);
    modport register (input reg_dst, input sp_step, input set_i, input set_nz);
endinterface : ucode_if

// ==== hw/cpu_registers.sv ====
`timescale 1ns/1ps

module cpu_registers
    import nes_cpu_pkg::*;
(
    input  logic            clock,
    input  logic            reset_n,
    ucode_if.register       ucode,
    cpu_bus_if.monitor      bus,
    output logic [7:0]      a,
    output logic [7:0]      x,
    output logic [7:0]      sp,
    output logic [15:0]     pc,
    output status_t         status
);

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            a <= 8'h00;
            x <= 8'h00;
        end
        else begin
            if (ucode.reg_dst == REGDST_A) begin
                a <= bus.r_data;
            end
            if (ucode.reg_dst == REGDST_X) begin
                x <= bus.r_data;
            end
        end
    end

    // PC loads one byte at a time from the vector fetch
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            pc <= PC_RESET;
        end
        else begin
            case (ucode.reg_dst)
                REGDST_PCLO: pc[7:0] <= bus.r_data;
                REGDST_PCHI: pc[15:8] <= bus.r_data;
                default: pc <= pc;
            endcase
        end
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            sp <= SP_RESET;
        end
        else begin
            case (ucode.sp_step)
                SPSTEP_INC: sp <= sp + 8'd1;
                SPSTEP_DEC: sp <= sp - 8'd1;
                default: sp <= sp;
            endcase
        end
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            status.raw <= STATUS_RESET;
        end
        else begin
            if (ucode.set_i) begin
                status.flags.i <= 1'b1;
            end
            // N and Z follow the byte being loaded
            if (ucode.set_nz) begin
                status.flags.n <= bus.r_data[7];
                status.flags.z <= (bus.r_data == 8'h00);
            end
        end
    end

endmodule : cpu_registers

// ==== hw/mem_inputs.sv ====
`timescale 1ns/1ps

module mem_inputs
    import nes_cpu_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic [15:0] cmd_addr,
    input  logic [7:0]  a,
    input  logic [7:0]  x,
    input  logic [7:0]  sp,
    input  logic [15:0] pc,
    input  status_t     status,
    ucode_if.datapath   ucode,
    cpu_bus_if.source   bus
);

    logic [7:0] addr_lo;
    logic [7:0] addr_hi;
    logic [7:0] addr_lo_q;
    logic [7:0] addr_hi_q;
    status_t    status_bs;

    always_comb begin
        case (ucode.addr_lo_src)
            ADDRLO_CMD: addr_lo = cmd_addr[7:0];
            ADDRLO_SP:  addr_lo = sp;
            ADDRLO_FE:  addr_lo = 8'hFE;
            ADDRLO_FF:  addr_lo = 8'hFF;
            default:    addr_lo = addr_lo_q;
        endcase
    end

    always_comb begin
        case (ucode.addr_hi_src)
            ADDRHI_CMD:   addr_hi = cmd_addr[15:8];
            ADDRHI_STACK: addr_hi = STACK_PAGE;
            ADDRHI_FF:    addr_hi = 8'hFF;
            default:      addr_hi = addr_hi_q;
        endcase
    end

    // Last driven address, replayed by the HOLD codes
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            addr_lo_q <= 8'h00;
            addr_hi_q <= 8'h00;
        end
        else begin
            addr_lo_q <= addr_lo;
            addr_hi_q <= addr_hi;
        end
    end

    assign bus.addr = {addr_hi, addr_lo};
    assign bus.r_en = ucode.mem_r_en;

    // Pushed status always has B and bit 5 set
    always_comb begin
        status_bs = status;
        status_bs.flags.b = 1'b1;
        status_bs.flags.unused = 1'b1;
    end

    always_comb begin
        case (ucode.wmem_src)
            WMEMSRC_A:         bus.w_data = a;
            WMEMSRC_X:         bus.w_data = x;
            WMEMSRC_PCHI:      bus.w_data = pc[15:8];
            WMEMSRC_PCLO:      bus.w_data = pc[7:0];
            WMEMSRC_STATUS_BS: bus.w_data = status_bs.raw;
            default:           bus.w_data = 8'h00;
        endcase
    end

endmodule : mem_inputs

// ==== hw/cpu_memory.sv ====
`timescale 1ns/1ps

module cpu_memory
    import nes_cpu_pkg::*;
(
    input  logic       clock,
    input  logic       reset_n,
    cpu_bus_if.target  bus
);

    logic [2047:0][7:0] ram;
    logic [7:0][7:0]    ppu_regs;
    logic [31:0][7:0]   io_regs;
    logic [7:0]         cart_mem [IO_END:16'hFFFF] = '{default: 8'h00};

    logic in_ram;
    logic in_ppu;
    logic in_io;

    assign in_ram = (bus.addr < RAM_END);
    assign in_ppu = !in_ram && (bus.addr < PPU_END);
    assign in_io  = !in_ram && !in_ppu && (bus.addr < IO_END);

    // Internal RAM, PPU and I/O registers
    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            ram      <= '0;
            ppu_regs <= '0;
            io_regs  <= '0;
        end
        else if (!bus.r_en) begin
            if (in_ram) begin
                ram[bus.addr[10:0]] <= bus.w_data;
            end
            else if (in_ppu) begin
                ppu_regs[bus.addr[2:0]] <= bus.w_data;
            end
            else if (in_io) begin
                io_regs[bus.addr[4:0]] <= bus.w_data;
            end
        end
    end

    // Cartridge space
    always_ff @(posedge clock) begin
        if (!bus.r_en && !in_ram && !in_ppu && !in_io) begin
            cart_mem[bus.addr] <= bus.w_data;
        end
    end

    always_ff @(posedge clock) begin
        if (bus.r_en) begin
            if (in_ram) begin
                bus.r_data <= ram[bus.addr[10:0]];
            end
            else if (in_ppu) begin
                bus.r_data <= ppu_regs[bus.addr[2:0]];
            end
            else if (in_io) begin
                bus.r_data <= io_regs[bus.addr[4:0]];
            end
            else begin
                bus.r_data <= cart_mem[bus.addr];
            end
        end
    end

endmodule : cpu_memory

// ==== hw/ucode_sequencer.sv ====
`timescale 1ns/1ps

module ucode_sequencer
    import nes_cpu_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  logic         cmd_valid,
    output logic         cmd_ready,
    input  logic [2:0]   cmd_op,
    input  logic [15:0]  cmd_addr,
    output logic         rsp_valid,
    input  logic         rsp_ready,
    output logic [15:0]  rsp_data,
    input  logic [7:0]   r_data,
    input  logic [15:0]  pc,
    ucode_if.controller  ucode,
    output logic [15:0]  cmd_addr_q
);

    logic [1:0] state_q;
    logic [2:0] op_q;
    logic [2:0] step_q;
    logic       last_step;
    logic       capture;
    logic       capture_pc;

    assign cmd_ready = (state_q == SEQ_IDLE);
    assign rsp_valid = (state_q == SEQ_RESP);

    // Micro-op word for the current command and step
    always_comb begin
        ucode.addr_lo_src = ADDRLO_HOLD;
        ucode.addr_hi_src = ADDRHI_HOLD;
        ucode.mem_r_en    = 1'b1;
        ucode.wmem_src    = WMEMSRC_A;
        ucode.reg_dst     = REGDST_NONE;
        ucode.sp_step     = SPSTEP_NONE;
        ucode.set_i       = 1'b0;
        ucode.set_nz      = 1'b0;
        last_step  = 1'b0;
        capture    = 1'b0;
        capture_pc = 1'b0;
        if (state_q == SEQ_STEP) begin
            case (op_q)
                CMD_LOAD_A, CMD_LOAD_X: begin
                    if (step_q == 3'd0) begin
                        ucode.addr_lo_src = ADDRLO_CMD;
                        ucode.addr_hi_src = ADDRHI_CMD;
                    end
                    else begin
                        ucode.reg_dst = (op_q == CMD_LOAD_A) ? REGDST_A : REGDST_X;
                        ucode.set_nz  = 1'b1;
                        capture   = 1'b1;
                        last_step = 1'b1;
                    end
                end
                CMD_STORE_A, CMD_STORE_X: begin
                    ucode.addr_lo_src = ADDRLO_CMD;
                    ucode.addr_hi_src = ADDRHI_CMD;
                    ucode.mem_r_en    = 1'b0;
                    ucode.wmem_src    = (op_q == CMD_STORE_A) ? WMEMSRC_A : WMEMSRC_X;
                    last_step = 1'b1;
                end
                CMD_PUSH_A: begin
                    ucode.addr_lo_src = ADDRLO_SP;
                    ucode.addr_hi_src = ADDRHI_STACK;
                    ucode.mem_r_en    = 1'b0;
                    ucode.sp_step     = SPSTEP_DEC;
                    last_step = 1'b1;
                end
                CMD_PULL_A: begin
                    case (step_q)
                        3'd0: ucode.sp_step = SPSTEP_INC;
                        3'd1: begin
                            ucode.addr_lo_src = ADDRLO_SP;
                            ucode.addr_hi_src = ADDRHI_STACK;
                        end
                        default: begin
                            ucode.reg_dst = REGDST_A;
                            ucode.set_nz  = 1'b1;
                            capture   = 1'b1;
                            last_step = 1'b1;
                        end
                    endcase
                end
                CMD_BRK: begin
                    case (step_q)
                        3'd0, 3'd1, 3'd2: begin
                            ucode.addr_lo_src = ADDRLO_SP;
                            ucode.addr_hi_src = ADDRHI_STACK;
                            ucode.mem_r_en    = 1'b0;
                            ucode.sp_step     = SPSTEP_DEC;
                            if (step_q == 3'd0) begin
                                ucode.wmem_src = WMEMSRC_PCHI;
                            end
                            else if (step_q == 3'd1) begin
                                ucode.wmem_src = WMEMSRC_PCLO;
                            end
                            else begin
                                ucode.wmem_src = WMEMSRC_STATUS_BS;
                                ucode.set_i    = 1'b1;
                            end
                        end
                        3'd3: begin
                            ucode.addr_lo_src = ADDRLO_FE;
                            ucode.addr_hi_src = ADDRHI_FF;
                        end
                        3'd4: begin
                            ucode.addr_lo_src = ADDRLO_FF;
                            ucode.reg_dst     = REGDST_PCLO;
                        end
                        3'd5: ucode.reg_dst = REGDST_PCHI;
                        default: begin
                            // PC is settled one cycle after the high byte lands
                            capture    = 1'b1;
                            capture_pc = 1'b1;
                            last_step  = 1'b1;
                        end
                    endcase
                end
                default: last_step = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clock, negedge reset_n) begin
        if (!reset_n) begin
            state_q <= SEQ_IDLE;
            op_q    <= CMD_LOAD_A;
            step_q  <= 3'd0;
        end
        else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (cmd_valid) begin
                        op_q    <= cmd_op;
                        step_q  <= 3'd0;
                        state_q <= SEQ_STEP;
                    end
                end
                SEQ_STEP: begin
                    if (last_step) begin
                        state_q <= capture ? SEQ_RESP : SEQ_IDLE;
                    end
                    else begin
                        step_q <= step_q + 3'd1;
                    end
                end
                SEQ_RESP: begin
                    if (rsp_ready) begin
                        state_q <= SEQ_IDLE;
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (cmd_valid && cmd_ready) begin
            cmd_addr_q <= cmd_addr;
        end
        if ((state_q == SEQ_STEP) && capture) begin
            rsp_data <= capture_pc ? pc : {8'h00, r_data};
        end
    end

endmodule : ucode_sequencer

// ==== hw/cpu_mem_top.sv ====
`timescale 1ns/1ps

module cpu_mem_top
    import nes_cpu_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    input  logic [2:0]  cmd_op,
    input  logic [15:0] cmd_addr,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output logic [15:0] rsp_data,
    output logic [15:0] pc,
    output logic [7:0]  status
);

    cpu_bus_if bus ();
    ucode_if   ucode ();

    logic [15:0] cmd_addr_q;
    logic [7:0]  a;
    logic [7:0]  x;
    logic [7:0]  sp;
    status_t     status_q;

    assign status = status_q.raw;

    ucode_sequencer u_sequencer (
        .clock      (clock),
        .reset_n    (reset_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .r_data     (bus.r_data),
        .pc         (pc),
        .ucode      (ucode.controller),
        .cmd_addr_q (cmd_addr_q)
    );

    mem_inputs u_mem_inputs (
        .clock    (clock),
        .reset_n  (reset_n),
        .cmd_addr (cmd_addr_q),
        .a        (a),
        .x        (x),
        .sp       (sp),
        .pc       (pc),
        .status   (status_q),
        .ucode    (ucode.datapath),
        .bus      (bus.source)
    );

    cpu_registers u_registers (
        .clock   (clock),
        .reset_n (reset_n),
        .ucode   (ucode.register),
        .bus     (bus.monitor),
        .a       (a),
        .x       (x),
        .sp      (sp),
        .pc      (pc),
        .status  (status_q)
    );

    cpu_memory u_memory (
        .clock   (clock),
        .reset_n (reset_n),
        .bus     (bus.target)
    );

endmodule : cpu_mem_top

// ==== bench/cpu_mem_model.svh ====
`ifndef CPU_MEM_MODEL_SVH
`define CPU_MEM_MODEL_SVH

// Reference state of the CPU and the NES memory map
logic [7:0]  model_mem [0:65535];
logic [7:0]  model_a;
logic [7:0]  model_x;
logic [7:0]  model_sp;
logic [15:0] model_pc;
status_t     model_status;

// Mirrored addresses map onto their base copy
function automatic logic [15:0] fold_address(input logic [15:0] addr);
    if (addr < RAM_END) begin
        return {5'b00000, addr[10:0]};
    end
    if (addr < PPU_END) begin
        return 16'h2000 | {13'd0, addr[2:0]};
    end
    return addr;
endfunction

function automatic void reset_model();
    for (int i = 0; i < 65536; i++) begin
        model_mem[i] = 8'h00;
    end
    model_a = 8'h00;
    model_x = 8'h00;
    model_sp = SP_RESET;
    model_pc = PC_RESET;
    model_status.raw = STATUS_RESET;
endfunction

function automatic void load_flags(input logic [7:0] value);
    model_status.flags.n = value[7];
    model_status.flags.z = (value == 8'h00);
endfunction

function automatic void push_byte(input logic [7:0] value);
    model_mem[fold_address({8'h01, model_sp})] = value;
    model_sp = model_sp - 8'd1;
endfunction

// SP steps up before the stack read
function automatic logic [7:0] pull_byte();
    model_sp = model_sp + 8'd1;
    return model_mem[fold_address({8'h01, model_sp})];
endfunction

// Applies one command and returns the response it should produce
function automatic logic [15:0] predict_command(
    input  logic [2:0]  op,
    input  logic [15:0] addr,
    output logic        has_rsp
);
    logic [7:0] value;
    status_t    pushed;
    has_rsp = 1'b1;
    value = 8'h00;
    case (op)
        CMD_LOAD_A: begin
            value = model_mem[fold_address(addr)];
            model_a = value;
            load_flags(value);
        end
        CMD_LOAD_X: begin
            value = model_mem[fold_address(addr)];
            model_x = value;
            load_flags(value);
        end
        CMD_STORE_A: begin
            model_mem[fold_address(addr)] = model_a;
            has_rsp = 1'b0;
        end
        CMD_STORE_X: begin
            model_mem[fold_address(addr)] = model_x;
            has_rsp = 1'b0;
        end
        CMD_PUSH_A: begin
            push_byte(model_a);
            has_rsp = 1'b0;
        end
        CMD_PULL_A: begin
            value = pull_byte();
            model_a = value;
            load_flags(value);
        end
        CMD_BRK: begin
            pushed = model_status;
            pushed.flags.b = 1'b1;
            pushed.flags.unused = 1'b1;
            push_byte(model_pc[15:8]);
            push_byte(model_pc[7:0]);
            push_byte(pushed.raw);
            model_status.flags.i = 1'b1;
            model_pc = {model_mem[16'hFFFF], model_mem[16'hFFFE]};
            return model_pc;
        end
        default: has_rsp = 1'b0;
    endcase
    return {8'h00, value};
endfunction

`endif

// ==== bench/cpu_mem_tb.sv ====
`timescale 1ns/1ps

module cpu_mem_tb
    import nes_cpu_pkg::*;
();

    localparam int CLOCK_PERIOD     = 20;
    localparam int BRK_ROUNDS       = 3;
    localparam int STORE_LOAD_ITERS = 20;
    localparam int MIRROR_ITERS     = 10;
    localparam int PUSH_PULL_ITERS  = 5;
    localparam int STACK_DEPTH      = 4;
    localparam int BP_CMDS          = 40;
    localparam int MIX_CMDS         = 300;
    localparam int TOTAL_CMDS = BRK_ROUNDS * 8 + STORE_LOAD_ITERS * 3 + MIRROR_ITERS * 5
        + PUSH_PULL_ITERS * 3 + STACK_DEPTH * 4 + BP_CMDS + MIX_CMDS;

    logic        clock;
    logic        reset_n;
    logic        cmd_valid;
    logic        cmd_ready;
    logic [2:0]  cmd_op;
    logic [15:0] cmd_addr;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [15:0] rsp_data;
    logic [15:0] pc;
    logic [7:0]  status;

    logic [15:0] expected_q [$];
    logic        ready_pattern [0:4095];
    logic        backpressure;

    `include "cpu_mem_model.svh"

    cpu_mem_top u_dut (
        .clock     (clock),
        .reset_n   (reset_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .pc        (pc),
        .status    (status)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] expected);
        report_failure($sformatf("mismatch %s: got 0x%04h, expected 0x%04h",
                                 name, got, expected));
    endtask

    task automatic check_state();
        assert (pc === model_pc) else report_mismatch("pc", pc, model_pc);
        assert (status === model_status.raw)
            else report_mismatch("status", {8'h00, status}, {8'h00, model_status.raw});
    endtask

    // Called on a falling edge
    task automatic wait_idle();
        while (cmd_ready !== 1'b1) begin
            @(negedge clock);
        end
    endtask

    task automatic send_command(input logic [2:0] op, input logic [15:0] addr);
        logic [15:0] expected;
        logic        has_rsp;
        wait_idle();
        check_state();
        cmd_valid = 1'b1;
        cmd_op = op;
        cmd_addr = addr;
        @(posedge clock);
        expected = predict_command(op, addr, has_rsp);
        if (has_rsp) begin
            expected_q.push_back(expected);
        end
        @(negedge clock);
        cmd_valid = 1'b0;
    endtask

    task automatic set_backpressure(input logic value);
        @(posedge clock);
        backpressure = value;
        @(negedge clock);
    endtask

    // Spread over RAM, PPU, I/O and cartridge space
    function automatic logic [15:0] pick_address();
        int          region;
        logic [31:0] offset;
        logic [31:0] cart;
        region = $urandom % 4;
        offset = $urandom;
        cart = 32'h4020 + offset % 32'hBFE0;
        case (region)
            0: return {3'b000, offset[12:0]};
            1: return {3'b001, offset[12:0]};
            2: return {11'h200, offset[4:0]};
            default: return cart[15:0];
        endcase
    endfunction

    // Top of the stack page where BRK leaves its bytes
    function automatic logic [15:0] stack_address();
        logic [31:0] offset;
        offset = $urandom;
        return {12'h01F, offset[3:0]};
    endfunction

    // Low stretches alternate with high ones
    task automatic fill_ready_pattern();
        int index;
        int len;
        index = 0;
        while (index < 4096) begin
            len = 1 + $urandom % 6;
            for (int j = 0; j < len && index < 4096; j++) begin
                ready_pattern[index] = 1'b0;
                index++;
            end
            len = 1 + $urandom % 4;
            for (int j = 0; j < len && index < 4096; j++) begin
                ready_pattern[index] = 1'b1;
                index++;
            end
        end
    endtask

    task automatic brk_rounds();
        repeat (BRK_ROUNDS) begin
            send_command(CMD_LOAD_A, stack_address());
            send_command(CMD_STORE_A, 16'hFFFE);
            send_command(CMD_LOAD_X, stack_address());
            send_command(CMD_STORE_X, 16'hFFFF);
            send_command(CMD_BRK, 16'h0000);
            wait_idle();
            check_state();
            repeat (3) begin
                send_command(CMD_PULL_A, 16'h0000);
            end
        end
    endtask

    task automatic store_then_load();
        logic [15:0] addr;
        for (int i = 0; i < STORE_LOAD_ITERS; i++) begin
            addr = pick_address();
            if (i % 2 == 0) begin
                send_command(CMD_LOAD_A, stack_address());
                send_command(CMD_STORE_A, addr);
                send_command(CMD_LOAD_X, addr);
            end
            else begin
                send_command(CMD_LOAD_X, stack_address());
                send_command(CMD_STORE_X, addr);
                send_command(CMD_LOAD_A, addr);
            end
        end
    endtask

    task automatic mirror_checks();
        logic [31:0] offset;
        logic [15:0] ram_addr;
        logic [15:0] ppu_addr;
        repeat (MIRROR_ITERS) begin
            offset = $urandom;
            ram_addr = {5'b00000, offset[10:0]};
            ppu_addr = {4'b0010, offset[23:12]};
            send_command(CMD_LOAD_A, stack_address());
            send_command(CMD_STORE_A, ram_addr);
            send_command(CMD_LOAD_X, ram_addr + (offset[11] ? 16'h0800 : 16'h1800));
            send_command(CMD_STORE_A, ppu_addr);
            send_command(CMD_LOAD_X, ppu_addr + 16'h0008);
        end
    endtask

    task automatic stack_checks();
        repeat (PUSH_PULL_ITERS) begin
            send_command(CMD_LOAD_A, stack_address());
            send_command(CMD_PUSH_A, 16'h0000);
            send_command(CMD_PULL_A, 16'h0000);
        end
        // Pushes go down from 0x01FD
        for (int d = 0; d < STACK_DEPTH; d++) begin
            send_command(CMD_LOAD_A, pick_address());
            send_command(CMD_PUSH_A, 16'h0000);
        end
        for (int d = 0; d < STACK_DEPTH; d++) begin
            send_command(CMD_LOAD_X, 16'h01FD - d[15:0]);
        end
        repeat (STACK_DEPTH) begin
            send_command(CMD_PULL_A, 16'h0000);
        end
    endtask

    task automatic random_commands(input int count, input logic responses_only);
        logic [2:0] op;
        int         pick;
        repeat (count) begin
            pick = $urandom % 7;
            if (responses_only) begin
                case (pick % 4)
                    0: op = CMD_LOAD_A;
                    1: op = CMD_LOAD_X;
                    2: op = CMD_PULL_A;
                    default: op = CMD_BRK;
                endcase
            end
            else begin
                op = pick[2:0];
            end
            send_command(op, pick_address());
        end
    endtask

    initial begin : response_check
        logic        stalled;
        logic [15:0] held;
        int          pattern_index;
        rsp_ready = 1'b0;
        stalled = 1'b0;
        held = 16'h0000;
        pattern_index = 0;
        @(posedge reset_n);
        forever begin
            @(negedge clock);
            if (stalled) begin
                assert (rsp_valid === 1'b1)
                    else report_failure("response dropped before it was accepted");
                assert (rsp_data === held) else report_mismatch("rsp_data", rsp_data, held);
            end
            if (rsp_valid === 1'b1) begin
                assert (cmd_ready === 1'b0)
                    else report_failure("cmd_ready high while a response is waiting");
            end
            if (backpressure) begin
                rsp_ready = ready_pattern[pattern_index % 4096];
                pattern_index++;
            end
            else begin
                rsp_ready = 1'b1;
            end
            if (rsp_valid === 1'b1 && rsp_ready) begin
                assert (expected_q.size() > 0)
                    else report_failure("response arrived with no command expecting one");
                assert (rsp_data === expected_q[0])
                    else report_mismatch("rsp_data", rsp_data, expected_q[0]);
                void'(expected_q.pop_front());
                stalled = 1'b0;
            end
            else begin
                stalled = (rsp_valid === 1'b1);
                held = rsp_data;
            end
        end
    end

    initial begin : watchdog
        #(CLOCK_PERIOD * (TOTAL_CMDS * 20 + 10));
        report_failure("timeout waiting for response");
    end

    initial begin
        clock = 1'b0;
        reset_n = 1'b0;
        cmd_valid = 1'b0;
        cmd_op = CMD_LOAD_A;
        cmd_addr = 16'h0000;
        backpressure = 1'b0;
        void'($urandom(32'h4d3d));
        fill_ready_pattern();
        reset_model();
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        assert (cmd_ready === 1'b1 && rsp_valid === 1'b0)
            else report_failure("handshake outputs wrong after reset");
        check_state();

        brk_rounds();
        store_then_load();
        mirror_checks();
        stack_checks();
        set_backpressure(1'b1);
        random_commands(BP_CMDS, 1'b1);
        set_backpressure(1'b0);
        random_commands(MIX_CMDS, 1'b0);

        wait_idle();
        assert (expected_q.size() == 0) else report_failure("expected response never arrived");
        check_state();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule : cpu_mem_tb

// ==== verilog.f ====
+incdir+bench
hw/nes_cpu_pkg.sv
hw/cpu_interfaces.sv
hw/cpu_registers.sv
hw/mem_inputs.sv
hw/cpu_memory.sv
hw/ucode_sequencer.sv
hw/cpu_mem_top.sv
bench/cpu_mem_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_mem

sources:
  - hw/nes_cpu_pkg.sv
  - hw/cpu_interfaces.sv
  - hw/cpu_registers.sv
  - hw/mem_inputs.sv
  - hw/cpu_memory.sv
  - hw/ucode_sequencer.sv
  - hw/cpu_mem_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/cpu_mem_tb.sv
